// File: cache/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   req_valid,
    input  cpu_req_t               req,
    output logic                   busy,
    output logic                   resp_valid,
    output cpu_resp_t              resp,
    output logic [word_addr_w-1:0] lookup_addr,
    input  logic                   hit,
    input  data_word_u             line_data,
    output logic                   wr_en,
    output logic [word_addr_w-1:0] wr_addr,
    output data_word_u             wr_data,
    output logic                   mem_strobe,
    output mem_req_t               mem_req,
    input  logic [byte_w-1:0]      mem_rdata
);

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_fill,
        st_write,
        st_respond
    } state_t;

    state_t                state_q;
    state_t                state_d;
    cpu_req_t              req_q;
    logic [beat_w-1:0]     beat_q;
    logic                  hit_q;
    data_word_u            fill_q;
    logic [byte_sel_w-1:0] beat_sel;
    logic [byte_sel_w-1:0] fill_sel;

    assign beat_sel = beat_q[byte_sel_w-1:0];
    assign fill_sel = beat_sel - 1'b1;       // read data lags its strobe by one beat.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= st_idle;
            beat_q  <= '0;
            hit_q   <= 1'b0;
        end else begin
            state_q <= state_d;
            case (state_q)
                st_idle: begin
                    beat_q <= '0;
                end
                st_lookup: begin
                    beat_q <= beat_w'(1);    // lane 0 goes out during the lookup.
                    hit_q  <= hit;
                end
                st_fill, st_write: begin
                    beat_q <= beat_q + 1'b1;
                end
                default: begin
                    beat_q <= beat_q;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == st_idle && req_valid) begin
            req_q <= req;
        end
        if (state_q == st_fill) begin
            fill_q.bytes[fill_sel] <= mem_rdata;
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: begin
                if (req_valid) begin
                    state_d = st_lookup;
                end
            end
            st_lookup: begin
                if (req_q.write) begin
                    state_d = st_write;
                end else if (hit) begin
                    state_d = st_idle;       // a read hit answers in this cycle.
                end else begin
                    state_d = st_fill;
                end
            end
            st_fill: begin
                if (beat_q == beat_w'(bytes_per_word)) begin
                    state_d = st_respond;
                end
            end
            st_write: begin
                if (beat_q == beat_w'(bytes_per_word - 1)) begin
                    state_d = st_respond;
                end
            end
            default: begin
                state_d = st_idle;
            end
        endcase
    end

    // byte beats on the memory bus, one lane per cycle.
    assign mem_strobe = (state_q == st_lookup && (req_q.write || !hit)) ||
                        (state_q == st_fill && beat_q < bytes_per_word) ||
                        (state_q == st_write);
    assign mem_req.rw    = req_q.write ? mem_write : mem_read;
    assign mem_req.addr  = {req_q.addr, beat_sel};
    assign mem_req.wdata = req_q.wdata.bytes[beat_sel];

    assign lookup_addr = req_q.addr;
    assign wr_addr     = req_q.addr;
    assign wr_data     = req_q.write ? req_q.wdata : fill_q;

    // write hits update the line at once; read misses fill it when they answer.
    assign wr_en = (state_q == st_lookup && req_q.write && hit) ||
                   (state_q == st_respond && !req_q.write);

    assign busy       = (state_q != st_idle);
    assign resp_valid = (state_q == st_lookup && !req_q.write && hit) ||
                        (state_q == st_respond);
    assign resp.hit   = (state_q == st_lookup) ? hit : hit_q;
    assign resp.rdata = (state_q == st_lookup) ? line_data : fill_q;

    // the requester has no back-pressure, so it must respect busy.
    a_no_req_while_busy: assert property (
        @(posedge clk) disable iff (!rst_n) req_valid |-> !busy
    ) else $error("request strobe while the cache is busy");

    a_resp_single_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |=> !resp_valid
    ) else $error("response strobe held for more than one cycle");

endmodule

// File: cache/cache_store.sv
`timescale 1ns/1ps

module cache_store import cache_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [word_addr_w-1:0] lookup_addr,
    output logic                   hit,
    output data_word_u             line_data,
    input  logic                   wr_en,
    input  logic [word_addr_w-1:0] wr_addr,
    input  data_word_u             wr_data
);

    logic [line_count-1:0] valid_q;
    logic [tag_w-1:0]      tag_q  [line_count];
    data_word_u            data_q [line_count];

    logic [index_w-1:0] lookup_index;
    logic [tag_w-1:0]   lookup_tag;
    logic [index_w-1:0] wr_index;
    logic [tag_w-1:0]   wr_tag;

    // low word-address bits pick the line, the rest is the tag.
    assign lookup_index = lookup_addr[index_w-1:0];
    assign lookup_tag   = lookup_addr[word_addr_w-1:index_w];
    assign wr_index     = wr_addr[index_w-1:0];
    assign wr_tag       = wr_addr[word_addr_w-1:index_w];

    assign hit       = valid_q[lookup_index] && (tag_q[lookup_index] == lookup_tag);
    assign line_data = data_q[lookup_index];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else if (wr_en) begin
            valid_q[wr_index] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_q[wr_index]  <= wr_tag;
            data_q[wr_index] <= wr_data;
        end
    end

endmodule

// File: common/cache_pkg.sv
package cache_pkg;

    localparam int word_addr_w    = 14;
    localparam int byte_addr_w    = 16;
    localparam int index_w        = 4;
    localparam int tag_w          = word_addr_w - index_w;
    localparam int bytes_per_word = 4;
    localparam int byte_w         = 8;

    localparam int line_count = 1 << index_w;
    localparam int mem_bytes  = 1 << byte_addr_w;

    // byte lane select, and a beat counter that can also count past the last lane.
    localparam int byte_sel_w = $clog2(bytes_per_word);
    localparam int beat_w     = byte_sel_w + 1;

    // memory bus direction, same encoding as the backing memory port.
    localparam logic mem_read  = 1'b1;
    localparam logic mem_write = 1'b0;

    // lane 0 is the least significant byte of the word.
    typedef union packed {
        logic [bytes_per_word*byte_w-1:0]        word;
        logic [bytes_per_word-1:0][byte_w-1:0]   bytes;
    } data_word_u;

    typedef struct packed {
        logic                   write;
        logic [word_addr_w-1:0] addr;    // word address.
        data_word_u             wdata;
    } cpu_req_t;

    typedef struct packed {
        data_word_u rdata;               // don't-care on a write acknowledge.
        logic       hit;
    } cpu_resp_t;

    typedef struct packed {
        logic                   rw;      // 1 reads, 0 writes.
        logic [byte_addr_w-1:0] addr;    // byte address.
        logic [byte_w-1:0]      wdata;
    } mem_req_t;

endpackage

// File: filelist.f
common/cache_pkg.sv
memory/sys_memory.sv
cache/cache_store.sv
cache/cache_ctrl.sv
rtl/cache_mem_top.sv
verif/tb_clock.sv
verif/tb_top.sv

// File: memory/sys_memory.sv
`timescale 1ns/1ps

module sys_memory import cache_pkg::*; (
    input  logic              clk,
    input  logic              mem_strobe,
    input  mem_req_t          mem_req,
    output logic [byte_w-1:0] mem_rdata
);

    logic [byte_w-1:0] mem [mem_bytes];

    // one access per strobe; read data appears the cycle after the strobe.
    always_ff @(posedge clk) begin
        if (mem_strobe) begin
            if (mem_req.rw == mem_read) begin
                mem_rdata <= mem[mem_req.addr];
            end else begin
                mem[mem_req.addr] <= mem_req.wdata;
            end
        end
    end

    // the controller must present a resolved address and direction with every strobe.
    a_strobe_addr_known: assert property (
        @(posedge clk) mem_strobe |-> !$isunknown({mem_req.rw, mem_req.addr})
    ) else $error("memory strobe with unknown address or direction");

    // write data has to be resolved too, or the array is silently corrupted.
    a_strobe_wdata_known: assert property (
        @(posedge clk) (mem_strobe && mem_req.rw == mem_write) |-> !$isunknown(mem_req.wdata)
    ) else $error("memory write strobe with unknown data");

endmodule

// File: rtl/cache_mem_top.sv
`timescale 1ns/1ps

module cache_mem_top import cache_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      req_valid,
    input  cpu_req_t  req,
    output logic      busy,
    output logic      resp_valid,
    output cpu_resp_t resp
);

    logic [word_addr_w-1:0] lookup_addr;
    logic                   store_hit;
    data_word_u             line_data;
    logic                   wr_en;
    logic [word_addr_w-1:0] wr_addr;
    data_word_u             wr_data;
    logic                   mem_strobe;
    mem_req_t               mem_req;
    logic [byte_w-1:0]      mem_rdata;

    cache_ctrl ctrl_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .req_valid   (req_valid),
        .req         (req),
        .busy        (busy),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .lookup_addr (lookup_addr),
        .hit         (store_hit),
        .line_data   (line_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data),
        .mem_strobe  (mem_strobe),
        .mem_req     (mem_req),
        .mem_rdata   (mem_rdata)
    );

    cache_store store_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .lookup_addr (lookup_addr),
        .hit         (store_hit),
        .line_data   (line_data),
        .wr_en       (wr_en),
        .wr_addr     (wr_addr),
        .wr_data     (wr_data)
    );

    sys_memory memory_i (
        .clk        (clk),
        .mem_strobe (mem_strobe),
        .mem_req    (mem_req),
        .mem_rdata  (mem_rdata)
    );

endmodule

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the cached memory testbench with Verilator and runs it.

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log build.log

verilator --binary --assert --timing -Wno-fatal \
    -f filelist.f --top-module tb_top -o sim_top > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/sim_top > sim.log 2>&1
cat sim.log

grep -qx "Test passed" sim.log \
    && echo "simulation result: PASS" \
    || { echo "simulation result: FAIL"; exit 1; }

exit 0

// File: verif/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns    = 8,
    parameter int reset_cycles = 5
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(period_ns / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        rst_n <= 1'b1;                       // released on a rising edge.
    end

endmodule

// File: verif/tb_top.sv
`timescale 1ns/1ps

module tb_top import cache_pkg::*; ();

    localparam int clk_period_ns = 8;
    localparam int reset_cycles  = 5;
    localparam int directed_reqs = 12;
    localparam int random_reqs   = 40;
    localparam int total_reqs    = directed_reqs + random_reqs;
    localparam int timeout_ns    = (total_reqs * 10 + reset_cycles) * clk_period_ns;
    localparam int lat_hit       = 1;
    localparam int lat_miss      = 6;
    localparam int lat_write     = 5;
    localparam int pool_size     = 8;

    logic      clk;
    logic      rst_n;
    logic      req_valid;
    cpu_req_t  req;
    logic      busy;
    logic      resp_valid;
    cpu_resp_t resp;

    // expectations for the request in flight.
    logic        exp_write;
    logic        exp_hit;
    logic [31:0] exp_rdata;
    logic [3:0]  exp_lat;
    logic [3:0]  since_req;
    int          req_count;
    int          resp_count;
    integer      seed;

    // reference model of memory contents and of the direct-mapped lines.
    logic [31:0]            model_mem [1 << word_addr_w];
    logic [line_count-1:0]  line_valid;
    logic [tag_w-1:0]       line_tag [line_count];
    logic [word_addr_w-1:0] pool [pool_size];
    logic [pool_size-1:0]   pool_written;

    tb_clock #(
        .period_ns    (clk_period_ns),
        .reset_cycles (reset_cycles)
    ) clock_i (
        .clk   (clk),
        .rst_n (rst_n)
    );

    cache_mem_top dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (req_valid),
        .req        (req),
        .busy       (busy),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    // cycles since the request strobe, so that the response cycle reads as the latency.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            since_req <= '0;
        end else if (req_valid) begin
            since_req <= 4'd1;
        end else if (busy && since_req != 4'hf) begin
            since_req <= since_req + 4'd1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_count <= 0;
        end else if (resp_valid) begin
            resp_count <= resp_count + 1;
        end
    end

    task automatic report_mismatch(input string sig, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("** Error at %0t ns: %s expected %h, actual %h", $time, sig, expected, actual);
        $display("Test failed");
        $fatal(1, "wrong value on %s", sig);
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        $display("Test failed");
        $fatal(1, "%s", what);
    endtask

    a_reset_not_busy: assert property (
        @(posedge clk) $rose(rst_n) |-> !busy
    ) else report_mismatch("busy", 32'd0, 32'($sampled(busy)));

    a_reset_no_resp: assert property (
        @(posedge clk) $rose(rst_n) |-> !resp_valid
    ) else report_mismatch("resp_valid", 32'd0, 32'($sampled(resp_valid)));

    a_reset_no_strobe: assert property (
        @(posedge clk) $rose(rst_n) |-> !dut_i.mem_strobe
    ) else report_mismatch("dut_i.mem_strobe", 32'd0, 32'($sampled(dut_i.mem_strobe)));

    a_resp_hit: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |-> resp.hit == exp_hit
    ) else report_mismatch("resp.hit", 32'($sampled(exp_hit)), 32'($sampled(resp.hit)));

    a_resp_rdata: assert property (
        @(posedge clk) disable iff (!rst_n)
        (resp_valid && !exp_write) |-> resp.rdata.word == exp_rdata
    ) else report_mismatch("resp.rdata", $sampled(exp_rdata), $sampled(resp.rdata.word));

    a_resp_latency: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |-> since_req == exp_lat
    ) else report_mismatch("resp_valid latency", 32'($sampled(exp_lat)),
                           32'($sampled(since_req)));

    a_resp_not_late: assert property (
        @(posedge clk) disable iff (!rst_n) (busy && !resp_valid) |-> since_req < exp_lat
    ) else report_failure("no response arrived within the expected latency");

    a_idle_after_resp: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |=> !busy
    ) else report_mismatch("busy", 32'd0, 32'($sampled(busy)));

    a_resp_one_cycle: assert property (
        @(posedge clk) disable iff (!rst_n) resp_valid |=> !resp_valid
    ) else report_mismatch("resp_valid", 32'd0, 32'($sampled(resp_valid)));

    initial begin
        #(timeout_ns);
        $display("Run stopped after %0d ns without finishing all requests", timeout_ns);
        $display("Test failed");
        $fatal(1, "the run timed out");
    end

    // sends one request once the cache is idle and waits for its response.
    task automatic issue_request(input logic write, input logic [word_addr_w-1:0] addr,
                                 input logic [31:0] data);
        logic [index_w-1:0] idx;
        logic [tag_w-1:0]   tag;
        logic               line_hit;
        idx      = addr[index_w-1:0];
        tag      = addr[word_addr_w-1:index_w];
        line_hit = line_valid[idx] && (line_tag[idx] == tag);
        while (busy) begin
            @(posedge clk);
        end
        req_valid       <= 1'b1;
        req.write       <= write;
        req.addr        <= addr;
        req.wdata.word  <= data;
        exp_write       <= write;
        exp_hit         <= line_hit;
        exp_rdata       <= model_mem[addr];
        exp_lat         <= write ? 4'(lat_write) : (line_hit ? 4'(lat_hit) : 4'(lat_miss));
        if (write) begin
            model_mem[addr] = data;              // no allocate, so the line map is untouched.
        end else if (!line_hit) begin
            line_valid[idx] = 1'b1;
            line_tag[idx]   = tag;
        end
        req_count++;
        @(posedge clk);
        req_valid <= 1'b0;
        do begin
            @(posedge clk);
        end while (!resp_valid);
    endtask

    initial begin
        logic [31:0] r;
        logic [2:0]  slot;
        logic        do_write;
        logic [31:0] data;
        req_valid    = 1'b0;
        req          = '0;
        exp_write    = 1'b0;
        exp_hit      = 1'b0;
        exp_rdata    = '0;
        exp_lat      = 4'(lat_miss);
        req_count    = 0;
        seed         = 56167;
        line_valid   = '0;
        pool_written = '0;
        pool[0] = 14'h0123;                      // index 3.
        pool[1] = 14'h0453;
        pool[2] = 14'h0bc3;
        pool[3] = 14'h0019;                      // index 9.
        pool[4] = 14'h3ff9;
        pool[5] = 14'h0207;
        pool[6] = 14'h1237;
        pool[7] = 14'h000c;

        wait (rst_n === 1'b1);
        @(posedge clk);

        // miss after a write, then a hit, then a write hit and a write miss.
        issue_request(1'b1, 14'h0123, 32'h1111_a0a0);
        issue_request(1'b0, 14'h0123, 32'h0);
        issue_request(1'b0, 14'h0123, 32'h0);
        issue_request(1'b1, 14'h0123, 32'h2222_b1b1);
        issue_request(1'b0, 14'h0123, 32'h0);
        issue_request(1'b1, 14'h0207, 32'h3333_c2c2);
        issue_request(1'b0, 14'h0207, 32'h0);

        // same index, different tags.
        issue_request(1'b1, 14'h0453, 32'h4444_d3d3);
        issue_request(1'b0, 14'h0453, 32'h0);
        issue_request(1'b0, 14'h0123, 32'h0);
        issue_request(1'b0, 14'h0453, 32'h0);
        issue_request(1'b0, 14'h0123, 32'h0);

        for (int i = 0; i < random_reqs; i++) begin
            r        = $random(seed);
            slot     = r[2:0];
            do_write = (r[4:3] == 2'b00) || !pool_written[slot];
            data     = $random(seed);
            issue_request(do_write, pool[slot], data);
            if (do_write) begin
                pool_written[slot] = 1'b1;
            end
        end

        repeat (2) @(posedge clk);
        if (resp_count == req_count && req_count == total_reqs) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Got %0d responses for %0d requests, %0d planned",
                     resp_count, req_count, total_reqs);
            $display("Test failed");
            $fatal(1, "response count does not match the requests");
        end
    end

endmodule
